//--- include/sysbus_cmds.svh
`ifndef SYSBUS_CMDS_SVH
`define SYSBUS_CMDS_SVH

// Command field in the top bit of a request tag
`define SYSBUS_READ     1'b1
`define SYSBUS_WRITE    1'b0

// Target codes in the middle four bits of a request tag
`define SYSBUS_MEMORY   4'b0001
`define SYSBUS_MMIO     4'b0011
`define SYSBUS_PORT     4'b0100
`define SYSBUS_IRQ      4'b1110

// Tag layout is {command, target, requester id}
`define SYSBUS_CMD_BITS     1
`define SYSBUS_TARGET_BITS  4

`endif

//--- design/sysbus_pkg.sv
package sysbus_pkg;
    `include "sysbus_cmds.svh"

    localparam int BUS_DATA_WIDTH   = 64;
    localparam int BUS_TAG_WIDTH    = 13;
    localparam int TAG_CMD_WIDTH    = `SYSBUS_CMD_BITS;
    localparam int TAG_TARGET_WIDTH = `SYSBUS_TARGET_BITS;
    localparam int TAG_ID_WIDTH     = BUS_TAG_WIDTH - TAG_CMD_WIDTH - TAG_TARGET_WIDTH;
    localparam int NUM_MASTERS      = 2;

    typedef logic [BUS_DATA_WIDTH-1:0]      bus_data_t;
    typedef logic [TAG_ID_WIDTH-1:0]        tag_id_t;
    typedef logic [$clog2(NUM_MASTERS)-1:0] master_sel_t;

    typedef struct packed {
        logic [TAG_CMD_WIDTH-1:0]    cmd;
        logic [TAG_TARGET_WIDTH-1:0] target;
        tag_id_t                     id;      // Routes the response back
    } bus_tag_t;

    // Requester ids double as arbiter master indices
    localparam tag_id_t REQ_ID_IFETCH = 8'd0;
    localparam tag_id_t REQ_ID_DFETCH = 8'd1;

    function automatic bus_tag_t read_tag(tag_id_t id);
        bus_tag_t tag;
        tag.cmd    = `SYSBUS_READ;
        tag.target = `SYSBUS_MEMORY;
        tag.id     = id;
        return tag;
    endfunction

endpackage

//--- design/fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_WIDTH       = 64;
    localparam int LINE_BITS        = 512;
    localparam int BEATS_PER_LINE   = 8;
    localparam int BEAT_BITS        = LINE_BITS / BEATS_PER_LINE;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BITS / 8);    // Byte offset in a line
    localparam int BEAT_COUNT_WIDTH = $clog2(BEATS_PER_LINE);

    typedef logic [LINE_BITS-1:0]        line_t;
    typedef logic [ADDR_WIDTH-1:0]       addr_t;
    typedef logic [BEAT_COUNT_WIDTH-1:0] beat_count_t;

endpackage

//--- design/sysbus_if.sv
`timescale 1ns/10ps

interface sysbus_if;
    import sysbus_pkg::*;

    // Request channel
    logic      reqcyc;
    bus_data_t req;
    bus_tag_t  reqtag;
    logic      reqack;

    // Response channel
    logic      respcyc;
    bus_data_t resp;
    bus_tag_t  resptag;
    logic      respack;

    modport master (
        output reqcyc,
        output req,
        output reqtag,
        input  reqack,
        input  respcyc,
        input  resp,
        input  resptag,
        output respack
    );

    modport slave (
        input  reqcyc,
        input  req,
        input  reqtag,
        output reqack,
        output respcyc,
        output resp,
        output resptag,
        input  respack
    );

endinterface

//--- design/line_fetch.sv
`timescale 1ns/10ps

module line_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  fetch_pkg::addr_t    address,
    input  sysbus_pkg::tag_id_t req_id,
    output fetch_pkg::line_t    line,
    output logic                line_valid,
    output logic                busy,
    sysbus_if.master            bus
);
    import sysbus_pkg::*;
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQUEST,
        S_COLLECT
    } state_t;

    state_t      state;
    state_t      state_next;
    addr_t       line_addr;
    tag_id_t     id_q;
    beat_count_t beat_cnt;
    logic        beat_fire;
    logic        last_beat;

    assign beat_fire = bus.respcyc && bus.respack;
    assign last_beat = beat_fire && (beat_cnt == beat_count_t'(BEATS_PER_LINE - 1));

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (start) begin
                    state_next = S_REQUEST;
                end
            end
            S_REQUEST: begin
                if (bus.reqack) begin
                    state_next = S_COLLECT;
                end
            end
            S_COLLECT: begin
                if (last_beat) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            beat_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            state      <= state_next;
            line_valid <= last_beat;                // One cycle after the eighth beat
            if (beat_fire) begin
                beat_cnt <= beat_cnt + 1'b1;        // Wraps to zero after the last beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            line_addr <= {address[ADDR_WIDTH-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
            id_q      <= req_id;
        end
        if (beat_fire) begin
            line[beat_cnt*BEAT_BITS +: BEAT_BITS] <= bus.resp;
        end
    end

    assign busy = (state != S_IDLE);

    assign bus.reqcyc  = (state == S_REQUEST);
    assign bus.req     = line_addr;
    assign bus.reqtag  = read_tag(id_q);
    assign bus.respack = (state == S_COLLECT);  // Never looks at respcyc

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !start
    ) else $error("line_fetch id %0d: start while busy", id_q);

    // Request must not move until the bus takes it
    a_request_stable: assert property (
        @(posedge clk) disable iff (reset)
        bus.reqcyc && !bus.reqack |=> bus.reqcyc && $stable(bus.req) && $stable(bus.reqtag)
    ) else $error("line_fetch id %0d: request changed before reqack", id_q);

endmodule

//--- design/sysbus_arbiter.sv
`timescale 1ns/10ps

module sysbus_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    sysbus_if.slave               m_ifetch,
    sysbus_if.slave               m_dfetch,
    output logic                  bus_reqcyc,
    output sysbus_pkg::bus_data_t bus_req,
    output sysbus_pkg::bus_tag_t  bus_reqtag,
    output logic                  bus_respack,
    input  logic                  bus_reqack,
    input  logic                  bus_respcyc,
    input  sysbus_pkg::bus_data_t bus_resp,
    input  sysbus_pkg::bus_tag_t  bus_resptag
);
    import sysbus_pkg::*;

    logic [NUM_MASTERS-1:0] pending;
    master_sel_t            rr_ptr;
    master_sel_t            grant;
    master_sel_t            grant_q;
    logic                   held;
    logic                   grant_dfetch;
    tag_id_t                resp_id;
    logic                   resp_to_ifetch;
    logic                   resp_to_dfetch;

    // Bit position is the requester id
    assign pending = {m_dfetch.reqcyc, m_ifetch.reqcyc};

    always_comb begin
        if (held) begin
            grant = grant_q;                        // Keep the bus steady until reqack
        end else if (pending[rr_ptr]) begin
            grant = rr_ptr;
        end else if (pending[master_sel_t'(rr_ptr + 1'b1)]) begin
            grant = master_sel_t'(rr_ptr + 1'b1);
        end else begin
            grant = rr_ptr;
        end
    end

    assign grant_dfetch = (grant == master_sel_t'(REQ_ID_DFETCH));

    assign bus_reqcyc = pending[grant];
    assign bus_req    = grant_dfetch ? m_dfetch.req : m_ifetch.req;
    assign bus_reqtag = grant_dfetch ? m_dfetch.reqtag : m_ifetch.reqtag;

    assign m_ifetch.reqack = bus_reqack && !grant_dfetch;
    assign m_dfetch.reqack = bus_reqack && grant_dfetch;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr  <= '0;
            grant_q <= '0;
            held    <= 1'b0;
        end else begin
            grant_q <= grant;
            held    <= bus_reqcyc && !bus_reqack;
            if (bus_reqcyc && bus_reqack) begin
                rr_ptr <= master_sel_t'(grant + 1'b1);  // Other master first next time
            end
        end
    end

    // Response steering by tag id
    assign resp_id        = bus_resptag.id;
    assign resp_to_ifetch = (resp_id == REQ_ID_IFETCH);
    assign resp_to_dfetch = (resp_id == REQ_ID_DFETCH);

    assign m_ifetch.respcyc = bus_respcyc && resp_to_ifetch;
    assign m_ifetch.resp    = bus_resp;
    assign m_ifetch.resptag = bus_resptag;

    assign m_dfetch.respcyc = bus_respcyc && resp_to_dfetch;
    assign m_dfetch.resp    = bus_resp;
    assign m_dfetch.resptag = bus_resptag;

    assign bus_respack = bus_respcyc &&
                         ((resp_to_ifetch && m_ifetch.respack) ||
                          (resp_to_dfetch && m_dfetch.respack));

    a_ack_with_cyc: assert property (
        @(posedge clk) disable iff (reset)
        bus_reqack |-> bus_reqcyc
    ) else $error("sysbus_arbiter: bus_reqack without bus_reqcyc");

    a_resp_id_known: assert property (
        @(posedge clk) disable iff (reset)
        bus_respcyc |-> (resp_to_ifetch || resp_to_dfetch)
    ) else $error("sysbus_arbiter: response tag id %0h has no requester", resp_id);

endmodule

//--- design/fetch_subsystem.sv
`timescale 1ns/10ps

module fetch_subsystem (
    input  logic                                    clk,
    input  logic                                    reset,

    // Instruction fetch port
    input  logic                                    ifetch_start,
    input  fetch_pkg::addr_t                        ifetch_address,
    output fetch_pkg::line_t                        ifetch_line,
    output logic                                    ifetch_valid,
    output logic                                    ifetch_busy,

    // Data fetch port
    input  logic                                    dfetch_start,
    input  fetch_pkg::addr_t                        dfetch_address,
    output fetch_pkg::line_t                        dfetch_line,
    output logic                                    dfetch_valid,
    output logic                                    dfetch_busy,

    // External system bus
    output logic                                    bus_reqcyc,
    output logic                                    bus_respack,
    output logic [sysbus_pkg::BUS_DATA_WIDTH-1:0]   bus_req,
    output logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]    bus_reqtag,
    input  logic                                    bus_respcyc,
    input  logic                                    bus_reqack,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0]   bus_resp,
    input  logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]    bus_resptag
);
    import sysbus_pkg::*;

    sysbus_if if_ifetch ();
    sysbus_if if_dfetch ();

    line_fetch i_ifetch (
        .clk        (clk),
        .reset      (reset),
        .start      (ifetch_start),
        .address    (ifetch_address),
        .req_id     (REQ_ID_IFETCH),
        .line       (ifetch_line),
        .line_valid (ifetch_valid),
        .busy       (ifetch_busy),
        .bus        (if_ifetch.master)
    );

    line_fetch i_dfetch (
        .clk        (clk),
        .reset      (reset),
        .start      (dfetch_start),
        .address    (dfetch_address),
        .req_id     (REQ_ID_DFETCH),
        .line       (dfetch_line),
        .line_valid (dfetch_valid),
        .busy       (dfetch_busy),
        .bus        (if_dfetch.master)
    );

    sysbus_arbiter i_arbiter (
        .clk         (clk),
        .reset       (reset),
        .m_ifetch    (if_ifetch.slave),
        .m_dfetch    (if_dfetch.slave),
        .bus_reqcyc  (bus_reqcyc),
        .bus_req     (bus_req),
        .bus_reqtag  (bus_reqtag),
        .bus_respack (bus_respack),
        .bus_reqack  (bus_reqack),
        .bus_respcyc (bus_respcyc),
        .bus_resp    (bus_resp),
        .bus_resptag (bus_resptag)
    );

endmodule

//--- verification/sysbus_memory_model.sv
`timescale 1ns/10ps

module sysbus_memory_model #(
    parameter sysbus_pkg::bus_data_t PATTERN = '0
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  bus_reqcyc,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_req,
    input  logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_reqtag,
    input  logic                                  bus_respack,
    output logic                                  bus_reqack,
    output logic                                  bus_respcyc,
    output logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_resp,
    output logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_resptag
);
    import sysbus_pkg::*;
    import fetch_pkg::*;

    logic [63:0]              rng;
    int unsigned              ack_wait;
    int unsigned              beat;
    bus_data_t                addr_q[$];          // Accepted requests in arrival order
    logic [BUS_TAG_WIDTH-1:0] tag_q[$];

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    initial begin
        rng         = 64'd34;
        ack_wait    = 0;
        beat        = 0;
        bus_reqack  = 1'b0;
        bus_respcyc = 1'b0;
        bus_resp    = '0;
        bus_resptag = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            bus_reqack  <= 1'b0;
            bus_respcyc <= 1'b0;
            ack_wait     = 0;
            beat         = 0;
            addr_q.delete();
            tag_q.delete();
        end else begin
            if (bus_respcyc && bus_respack) begin
                if (beat == BEATS_PER_LINE - 1) begin
                    addr_q.delete(0);             // Burst done
                    tag_q.delete(0);
                    beat = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            if (!(bus_respcyc && !bus_respack)) begin
                rng = xorshift64(rng);
                if (addr_q.size() != 0 && rng[1:0] != 2'd0) begin
                    bus_respcyc <= 1'b1;
                    bus_resp    <= (addr_q[0] + bus_data_t'(8 * beat)) ^ PATTERN;
                    bus_resptag <= tag_q[0];
                end else begin
                    bus_respcyc <= 1'b0;              // Idle gap
                end
            end

            // New requests only reach the response side a cycle later
            if (bus_reqack) begin
                bus_reqack <= 1'b0;
                addr_q.push_back(bus_req);
                tag_q.push_back(bus_reqtag);
                rng      = xorshift64(rng);
                ack_wait = rng[5:4];                  // Next ack delay of 0 to 3 cycles
            end else if (bus_reqcyc) begin
                if (ack_wait == 0) begin
                    bus_reqack <= 1'b1;
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

endmodule

//--- verification/tb_fetch_subsystem.sv
`timescale 1ns/10ps
`include "sysbus_cmds.svh"

module tb_fetch_subsystem;
    import sysbus_pkg::*;
    import fetch_pkg::*;

    localparam bus_data_t PATTERN    = 64'hA5C3_0F96_5A3C_F069;
    localparam int        TIMEOUT    = 400;
    localparam int        NUM_ROUNDS = 24;

    logic                      clk;
    logic                      reset;
    logic                      ifetch_start;
    addr_t                     ifetch_address;
    line_t                     ifetch_line;
    logic                      ifetch_valid;
    logic                      ifetch_busy;
    logic                      dfetch_start;
    addr_t                     dfetch_address;
    line_t                     dfetch_line;
    logic                      dfetch_valid;
    logic                      dfetch_busy;
    logic                      bus_reqcyc;
    logic                      bus_respack;
    logic [BUS_DATA_WIDTH-1:0] bus_req;
    logic [BUS_TAG_WIDTH-1:0]  bus_reqtag;
    logic                      bus_respcyc;
    logic                      bus_reqack;
    logic [BUS_DATA_WIDTH-1:0] bus_resp;
    logic [BUS_TAG_WIDTH-1:0]  bus_resptag;

    line_t       exp_line_i;
    line_t       exp_line_d;
    addr_t       exp_addr_i;
    addr_t       exp_addr_d;
    int unsigned starts_i;
    int unsigned starts_d;
    int unsigned valids_i;
    int unsigned valids_d;
    int unsigned errors;
    logic [63:0] rng;

    fetch_subsystem i_fetch_subsystem (.*);

    sysbus_memory_model #(.PATTERN(PATTERN)) i_memory (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    function automatic addr_t align_line(input addr_t a);
        return a & ~((addr_t'(1) << LINE_OFFSET_BITS) - 1);
    endfunction

    // Beat k holds the word at base + 8k
    function automatic line_t expected_line(input addr_t a);
        line_t l;
        addr_t base;
        base = align_line(a);
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            l[k*BUS_DATA_WIDTH +: BUS_DATA_WIDTH] = (base + addr_t'(8 * k)) ^ PATTERN;
        end
        return l;
    endfunction

    task automatic launch(input logic go_i, input logic go_d);
        addr_t a_i;
        addr_t a_d;
        rng = xorshift64(rng);
        a_i = rng;
        rng = xorshift64(rng);
        a_d = rng;
        @(posedge clk);
        if (go_i) begin
            ifetch_start   <= 1'b1;
            ifetch_address <= a_i;
            exp_addr_i     <= align_line(a_i);
            exp_line_i     <= expected_line(a_i);
            starts_i       <= starts_i + 1;
        end
        if (go_d) begin
            dfetch_start   <= 1'b1;
            dfetch_address <= a_d;
            exp_addr_d     <= align_line(a_d);
            exp_line_d     <= expected_line(a_d);
            starts_d       <= starts_d + 1;
        end
        @(posedge clk);
        ifetch_start <= 1'b0;
        dfetch_start <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (valids_i != starts_i || valids_d != starts_d) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout after %0d cycles waiting for a line valid", TIMEOUT);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            valids_i <= 0;
            valids_d <= 0;
        end else begin
            if (ifetch_valid) valids_i <= valids_i + 1;
            if (dfetch_valid) valids_d <= valids_d + 1;
        end
    end

    a_quiet_until_start: assert property (@(posedge clk) disable iff (reset)
        (starts_i + starts_d == 0) |-> !(bus_reqcyc || bus_respack || ifetch_valid ||
                                         dfetch_valid || ifetch_busy || dfetch_busy))
    else begin
        errors++;
        $display("Bus or port outputs went active before any start");
    end

    a_req_tag: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc |-> bus_reqtag[BUS_TAG_WIDTH-1:TAG_ID_WIDTH] == {`SYSBUS_READ, `SYSBUS_MEMORY})
    else begin
        errors++;
        $display("Mismatch bus_reqtag: got %h, expected %h", $sampled(bus_reqtag),
                 {`SYSBUS_READ, `SYSBUS_MEMORY, $sampled(bus_reqtag[TAG_ID_WIDTH-1:0])});
    end

    a_req_id: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc |-> (bus_reqtag[TAG_ID_WIDTH-1:0] == REQ_ID_IFETCH ||
                        bus_reqtag[TAG_ID_WIDTH-1:0] == REQ_ID_DFETCH))
    else begin
        errors++;
        $display("Request tag carries an unknown requester id");
    end

    a_req_addr_i: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc && bus_reqtag[TAG_ID_WIDTH-1:0] == REQ_ID_IFETCH |-> bus_req == exp_addr_i)
    else begin
        errors++;
        $display("Mismatch bus_req: got %h, expected %h", $sampled(bus_req), $sampled(exp_addr_i));
    end

    a_req_addr_d: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc && bus_reqtag[TAG_ID_WIDTH-1:0] == REQ_ID_DFETCH |-> bus_req == exp_addr_d)
    else begin
        errors++;
        $display("Mismatch bus_req: got %h, expected %h", $sampled(bus_req), $sampled(exp_addr_d));
    end

    // Request must hold while the memory withholds reqack
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
    else begin
        errors++;
        $display("Bus request changed while reqack was withheld");
    end

    a_line_i: assert property (@(posedge clk) disable iff (reset)
        ifetch_valid |-> ifetch_line == exp_line_i)
    else begin
        errors++;
        $display("Mismatch ifetch_line: got %h, expected %h", $sampled(ifetch_line),
                 $sampled(exp_line_i));
    end

    a_line_d: assert property (@(posedge clk) disable iff (reset)
        dfetch_valid |-> dfetch_line == exp_line_d)
    else begin
        errors++;
        $display("Mismatch dfetch_line: got %h, expected %h", $sampled(dfetch_line),
                 $sampled(exp_line_d));
    end

    a_busy_rise_i: assert property (@(posedge clk) disable iff (reset)
        ifetch_start |=> ifetch_busy)
    else begin
        errors++;
        $display("Mismatch ifetch_busy: got %h, expected 1", $sampled(ifetch_busy));
    end

    a_busy_rise_d: assert property (@(posedge clk) disable iff (reset)
        dfetch_start |=> dfetch_busy)
    else begin
        errors++;
        $display("Mismatch dfetch_busy: got %h, expected 1", $sampled(dfetch_busy));
    end

    a_busy_fall_i: assert property (@(posedge clk) disable iff (reset)
        $fell(ifetch_busy) |-> ifetch_valid)
    else begin
        errors++;
        $display("ifetch_busy fell without a line valid pulse");
    end

    a_busy_fall_d: assert property (@(posedge clk) disable iff (reset)
        $fell(dfetch_busy) |-> dfetch_valid)
    else begin
        errors++;
        $display("dfetch_busy fell without a line valid pulse");
    end

    a_one_valid_i: assert property (@(posedge clk) disable iff (reset)
        ifetch_valid |-> valids_i < starts_i ##1 !ifetch_valid)
    else begin
        errors++;
        $display("ifetch_valid pulsed without an outstanding fetch or for too long");
    end

    a_one_valid_d: assert property (@(posedge clk) disable iff (reset)
        dfetch_valid |-> valids_d < starts_d ##1 !dfetch_valid)
    else begin
        errors++;
        $display("dfetch_valid pulsed without an outstanding fetch or for too long");
    end

    initial begin
        reset          = 1'b1;
        ifetch_start   = 1'b0;
        ifetch_address = '0;
        dfetch_start   = 1'b0;
        dfetch_address = '0;
        exp_line_i     = '0;
        exp_line_d     = '0;
        exp_addr_i     = '0;
        exp_addr_d     = '0;
        starts_i       = 0;
        starts_d       = 0;
        errors         = 0;
        rng            = 64'd34;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);                    // Idle window after reset
        launch(1'b1, 1'b0);
        wait_done();
        launch(1'b0, 1'b1);
        wait_done();
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            rng = xorshift64(rng);
            case (rng[1:0])
                2'd0: launch(1'b1, 1'b0);
                2'd1: launch(1'b0, 1'b1);
                2'd2: launch(1'b1, 1'b1);             // Both ports in the same cycle
                default: begin
                    launch(1'b1, 1'b0);
                    repeat (rng[3:2]) @(posedge clk);
                    launch(1'b0, 1'b1);
                end
            endcase
            wait_done();
        end
        repeat (4) @(posedge clk);
        $display("Lines checked: ifetch %0d, dfetch %0d; errors %0d", valids_i, valids_d, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
design/sysbus_pkg.sv
design/fetch_pkg.sv
design/sysbus_if.sv
design/line_fetch.sv
design/sysbus_arbiter.sv
design/fetch_subsystem.sv
verification/sysbus_memory_model.sv
verification/tb_fetch_subsystem.sv
